/* project.f */
uart_tx_pkg.sv
mmio_cmd_if.sv
axil_mmio_bridge.sv
uart_tx_queue.sv
uart_serializer.sv
uart_tx_periph.sv
tb_uart_tx_periph.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_uart_tx_periph \
    -f project.f \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
    exit 0
fi
exit 1

/* tb_uart_tx_periph.sv */
`default_nettype none

module tb_uart_tx_periph;
    timeunit 1ns;
    timeprecision 100ps;

    import uart_tx_pkg::*;

    localparam int clks_per_bit = 8;
    localparam int rounds = 7;
    // Worst case bytes over tests 3, 4 and 5
    localparam int max_bytes = 40 + rounds * 80 + 16;
    localparam int timeout_cycles = max_bytes * 10 * clks_per_bit * 2 + 5000;

    logic      clk;
    logic      rst;
    addr_t     awaddr;
    logic      awvalid;
    logic      awready;
    data_t     wdata;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;
    addr_t     araddr;
    logic      arvalid;
    logic      arready;
    data_t     rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;
    logic      tx;

    data_t      model_mem [buf_words];
    ptr_t       model_head;
    ptr_t       model_tail;
    logic [7:0] exp_q [$];
    logic [7:0] rx_q [$];

    int    err_count;
    int    check_count;
    int    tests_run;
    int    tests_failed;
    int    test_err_base;
    string test_name;
    int    cycle_count;

    uart_tx_periph #(
        .clks_per_bit (clks_per_bit)
    ) DUT (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .tx      (tx)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, DUT stopped responding", cycle_count);
        $display("Verification failed");
        $finish;
    end

    // Frame decoder, samples tx near the middle of each bit
    initial begin : tx_monitor
        logic [7:0] rx_byte;
        forever begin
            @(negedge clk);
            if (!rst && !tx) begin
                repeat (clks_per_bit / 2) @(negedge clk);
                if (tx) begin
                    $display("Start bit on tx did not stay low to mid-bit");
                    err_count++;
                end else begin
                    for (int i = 0; i < 8; i++) begin
                        repeat (clks_per_bit) @(negedge clk);
                        rx_byte[i] = tx;
                    end
                    repeat (clks_per_bit) @(negedge clk);
                    if (!tx) begin
                        $display("Stop bit on tx is low, framing error");
                        err_count++;
                    end
                    rx_q.push_back(rx_byte);
                end
            end
        end
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %s: got 0x%08h expected 0x%08h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %s: got 0x%01h expected 0x%01h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %s: got 0x%02h expected 0x%02h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err_base = err_count;
        tests_run++;
    endtask

    task automatic finish_test();
        if (err_count == test_err_base) begin
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            $display("test %0d %s: FAILED, %0d errors", tests_run, test_name,
                     err_count - test_err_base);
            tests_failed++;
        end
    endtask

    // AW and W start independently, each after its own random delay
    task automatic axi_write(input addr_t addr, input data_t data, output axi_resp_t resp);
        int   aw_dly;
        int   w_dly;
        int   b_dly;
        int   cyc;
        logic aw_done;
        logic w_done;
        logic b_done;
        aw_dly = $urandom_range(0, 3);
        w_dly = $urandom_range(0, 3);
        b_dly = $urandom_range(0, 4);
        aw_done = 1'b0;
        w_done = 1'b0;
        b_done = 1'b0;
        cyc = 0;
        awaddr = addr;
        wdata = data;
        while (!(aw_done && w_done)) begin
            if (!aw_done && cyc >= aw_dly) begin
                awvalid = 1'b1;
            end
            if (!w_done && cyc >= w_dly) begin
                wvalid = 1'b1;
            end
            @(negedge clk);
            if (awvalid && awready) begin
                aw_done = 1'b1;
            end
            if (wvalid && wready) begin
                w_done = 1'b1;
            end
            @(posedge clk);
            #2;
            if (aw_done) begin
                awvalid = 1'b0;
            end
            if (w_done) begin
                wvalid = 1'b0;
            end
            cyc++;
        end
        while (!b_done) begin
            @(negedge clk);
            b_done = bvalid;
            @(posedge clk);
            #2;
        end
        repeat (b_dly) begin
            @(posedge clk);
            #2;
        end
        bready = 1'b1;
        @(negedge clk);
        resp = bresp;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, output data_t data, output axi_resp_t resp);
        int   ar_dly;
        int   r_dly;
        logic done;
        ar_dly = $urandom_range(0, 3);
        r_dly = $urandom_range(0, 4);
        araddr = addr;
        repeat (ar_dly) begin
            @(posedge clk);
            #2;
        end
        arvalid = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = arready;
            @(posedge clk);
            #2;
        end
        arvalid = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = rvalid;
            @(posedge clk);
            #2;
        end
        repeat (r_dly) begin
            @(posedge clk);
            #2;
        end
        rready = 1'b1;
        @(negedge clk);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic read_expect(input addr_t addr, input data_t exp_data,
                               input axi_resp_t exp_resp);
        data_t     d;
        axi_resp_t r;
        axi_read(addr, d, r);
        check_resp("rresp", r, exp_resp);
        check_data("rdata", d, exp_data);
    endtask

    // Ring byte rule: word from the upper pointer bits, byte from the lower two
    function automatic logic [7:0] model_byte(input ptr_t p);
        data_t shifted;
        shifted = model_mem[p[7:2]] >> (p[1:0] * 8);
        return shifted[7:0];
    endfunction

    task automatic advance_tail(input int n);
        ptr_t      p;
        ptr_t      new_tail;
        axi_resp_t r;
        p = model_tail;
        new_tail = model_tail + ptr_t'(n);
        repeat (n) begin
            exp_q.push_back(model_byte(p));
            p = p + 8'd1;
        end
        model_tail = new_tail;
        axi_write(tail_offset, {24'b0, new_tail}, r);
        check_resp("bresp", r, okay);
    endtask

    task automatic collect_bytes(input int n);
        logic [7:0] got;
        logic [7:0] exp;
        for (int i = 0; i < n; i++) begin
            while (rx_q.size() == 0) begin
                @(posedge clk);
                #2;
            end
            got = rx_q.pop_front();
            exp = exp_q.pop_front();
            check_byte("tx byte", got, exp);
            model_head = model_head + 8'd1;
        end
    endtask

    initial begin : main
        int unsigned seed_ret;
        data_t       d;
        axi_resp_t   r;
        addr_t       ad;
        int          n;
        int          a;
        int          b;
        int          w;
        seed_ret = $urandom(32'h3d8b_044e);
        err_count = 0;
        check_count = 0;
        tests_run = 0;
        tests_failed = 0;
        model_head = '0;
        model_tail = '0;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test("reset state");
        read_expect(head_offset, 32'h0, okay);
        read_expect(tail_offset, 32'h0, okay);
        if (tx !== 1'b1 || rx_q.size() != 0) begin
            $display("tx line did not stay idle high after reset");
            err_count++;
        end
        finish_test();

        start_test("buffer write and read back");
        for (w = 0; w < buf_words; w++) begin
            d = $urandom;
            axi_write(addr_t'(w * 4), d, r);
            check_resp("bresp", r, okay);
            model_mem[w] = d;
        end
        repeat (32) begin
            w = $urandom_range(0, buf_words - 1);
            d = $urandom;
            axi_write(addr_t'(w * 4), d, r);
            check_resp("bresp", r, okay);
            model_mem[w] = d;
        end
        for (w = 0; w < buf_words; w++) begin
            read_expect(addr_t'(w * 4), model_mem[w], okay);
        end
        finish_test();

        start_test("single tail advance");
        n = $urandom_range(1, 40);
        advance_tail(n);
        collect_bytes(n);
        read_expect(head_offset, {24'b0, model_tail}, okay);
        finish_test();

        start_test("tail advance while draining");
        repeat (rounds) begin
            a = $urandom_range(20, 40);
            b = $urandom_range(20, 40);
            advance_tail(a);
            collect_bytes(3);
            advance_tail(b);
            collect_bytes(a + b - 3);
            read_expect(head_offset, {24'b0, model_tail}, okay);
        end
        finish_test();

        start_test("head write and bad addresses");
        // Low byte differs from head so an accepted write would show
        d = $urandom;
        d[7:0] = ~model_head;
        axi_write(head_offset, d, r);
        check_resp("bresp", r, okay);
        read_expect(head_offset, {24'b0, model_head}, okay);
        for (int k = 0; k < 8; k++) begin
            ad = addr_t'($urandom_range(12'h105, 12'hfff));
            if (k % 2 == 0) begin
                axi_write(ad, $urandom, r);
                check_resp("bresp", r, slverr);
            end else begin
                read_expect(ad, 32'h0, slverr);
            end
        end
        read_expect(head_offset, {24'b0, model_head}, okay);
        read_expect(tail_offset, {24'b0, model_tail}, okay);
        for (w = 0; w < buf_words; w++) begin
            read_expect(addr_t'(w * 4), model_mem[w], okay);
        end
        n = $urandom_range(1, 16);
        advance_tail(n);
        collect_bytes(n);
        read_expect(head_offset, {24'b0, model_tail}, okay);
        // Line must stay quiet once the ring is empty
        repeat (12 * clks_per_bit) @(posedge clk);
        if (rx_q.size() != 0) begin
            $display("Unexpected extra bytes seen on tx after draining");
            err_count++;
        end
        finish_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* uart_tx_periph.sv */
`default_nettype none

module uart_tx_periph #(
    parameter int clks_per_bit = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  uart_tx_pkg::addr_t     awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  uart_tx_pkg::data_t     wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output uart_tx_pkg::axi_resp_t bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  uart_tx_pkg::addr_t     araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output uart_tx_pkg::data_t     rdata,
    output uart_tx_pkg::axi_resp_t rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output logic                   tx
);

    logic [7:0] byte_data;
    logic       byte_start;
    logic       byte_ready;

    mmio_cmd_if cmd_bus ();

    axil_mmio_bridge u_bridge (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cmd     (cmd_bus.master)
    );

    uart_tx_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd_bus.slave),
        .byte_data  (byte_data),
        .byte_start (byte_start),
        .byte_ready (byte_ready)
    );

    uart_serializer #(
        .clks_per_bit (clks_per_bit)
    ) u_serializer (
        .clk        (clk),
        .rst        (rst),
        .byte_data  (byte_data),
        .byte_start (byte_start),
        .byte_ready (byte_ready),
        .tx         (tx)
    );

endmodule

`default_nettype wire

/* uart_serializer.sv */
`default_nettype none

module uart_serializer #(
    parameter int clks_per_bit = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] byte_data,
    input  logic       byte_start,
    output logic       byte_ready,
    output logic       tx
);
    import uart_tx_pkg::*;

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);

    ser_state_t       state;
    logic [cnt_w-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic             bit_end;

    assign bit_end    = (cnt == cnt_last);
    assign byte_ready = (state == ser_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ser_idle;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else if (state == ser_idle) begin
            cnt <= '0;
            if (byte_start) begin
                state <= ser_start_bit;
                tx    <= 1'b0;
            end
        end else begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            if (bit_end) begin
                case (state)
                    ser_start_bit: begin
                        state   <= ser_data_bits;
                        bit_idx <= '0;
                        tx      <= shift_q[0];
                    end
                    ser_data_bits: begin
                        if (bit_idx == 3'd7) begin
                            state <= ser_stop_bit;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift_q[0];
                        end
                    end
                    default: state <= ser_idle;
                endcase
            end
        end
    end

    // Next data bit always sits in bit 0
    always_ff @(posedge clk) begin
        if ((state == ser_idle) && byte_start) begin
            shift_q <= byte_data;
        end else if (bit_end && ((state == ser_start_bit) || (state == ser_data_bits))) begin
            shift_q <= shift_q >> 1;
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (rst)
        (state == ser_idle) |-> tx);

endmodule

`default_nettype wire

/* uart_tx_queue.sv */
`default_nettype none

module uart_tx_queue (
    input  logic       clk,
    input  logic       rst,
    mmio_cmd_if.slave  cmd,
    output logic [7:0] byte_data,
    output logic       byte_start,
    input  logic       byte_ready
);
    import uart_tx_pkg::*;

    data_t        buf_mem [buf_words];
    ptr_t         head;
    ptr_t         tail;
    queue_state_t state;
    data_t        word_q;
    logic [5:0]   cmd_word;
    logic         is_buf;
    logic         is_head;
    logic         is_tail;

    // Register decode
    assign cmd_word = cmd.addr[7:2];
    assign is_buf   = (cmd.addr < head_offset) && (cmd.addr[1:0] == 2'b00);
    assign is_head  = (cmd.addr == head_offset);
    assign is_tail  = (cmd.addr == tail_offset);

    always_ff @(posedge clk) begin
        if (cmd.start) begin
            cmd.err <= !(is_buf || is_head || is_tail);
            if (is_buf) begin
                cmd.rdata <= buf_mem[cmd_word];
            end else if (is_head) begin
                cmd.rdata <= {24'b0, head};
            end else if (is_tail) begin
                cmd.rdata <= {24'b0, tail};
            end else begin
                cmd.rdata <= '0;
            end
            if (cmd.write && is_buf) begin
                buf_mem[cmd_word] <= cmd.wdata;
            end
        end
    end

    // Head writes are dropped, only the drain engine moves head
    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= '0;
        end else if (cmd.start && cmd.write && is_tail) begin
            tail <= cmd.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= q_idle;
            head       <= '0;
            byte_start <= 1'b0;
        end else begin
            byte_start <= 1'b0;
            case (state)
                q_idle: begin
                    if (head != tail) begin
                        state <= q_fetch;
                    end
                end
                q_fetch: state <= q_wait_ready;
                q_wait_ready: begin
                    if (byte_ready) begin
                        byte_start <= 1'b1;
                        head       <= head + 1'b1;
                        state      <= q_idle;
                    end
                end
                default: state <= q_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == q_fetch) begin
            word_q <= buf_mem[head[7:2]];
        end
        // Low pointer bits pick the byte, LSB first within a word
        if ((state == q_wait_ready) && byte_ready) begin
            byte_data <= word_q[{head[1:0], 3'b000} +: 8];
        end
    end

    // Serializer must still be idle while the pulse is out
    a_start_with_ready: assert property (@(posedge clk) disable iff (rst)
        byte_start |-> byte_ready);

endmodule

`default_nettype wire

/* axil_mmio_bridge.sv */
`default_nettype none

module axil_mmio_bridge (
    input  logic                  clk,
    input  logic                  rst,
    input  uart_tx_pkg::addr_t    awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  uart_tx_pkg::data_t    wdata,
    input  logic                  wvalid,
    output logic                  wready,
    output uart_tx_pkg::axi_resp_t bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  uart_tx_pkg::addr_t    araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output uart_tx_pkg::data_t    rdata,
    output uart_tx_pkg::axi_resp_t rresp,
    output logic                  rvalid,
    input  logic                  rready,
    mmio_cmd_if.master            cmd
);
    import uart_tx_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_wait_w,
        st_wait_aw,
        st_cmd,
        st_latch,
        st_resp
    } bridge_state_t;

    bridge_state_t state;
    logic          write_q;
    addr_t         addr_q;
    data_t         wdata_q;
    data_t         rdata_q;
    axi_resp_t     resp_q;
    logic          ar_hs;
    logic          aw_hs;
    logic          w_hs;

    // Reads take priority at idle
    assign arready = (state == st_idle) && arvalid;
    assign awready = awvalid && (((state == st_idle) && !arvalid) || (state == st_wait_aw));
    assign wready  = wvalid && (((state == st_idle) && !arvalid) || (state == st_wait_w));

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            write_q <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (arvalid) begin
                        write_q <= 1'b0;
                        state   <= st_cmd;
                    end else if (awvalid && wvalid) begin
                        write_q <= 1'b1;
                        state   <= st_cmd;
                    end else if (awvalid) begin
                        write_q <= 1'b1;
                        state   <= st_wait_w;
                    end else if (wvalid) begin
                        write_q <= 1'b1;
                        state   <= st_wait_aw;
                    end
                end
                st_wait_w: begin
                    if (wvalid) begin
                        state <= st_cmd;
                    end
                end
                st_wait_aw: begin
                    if (awvalid) begin
                        state <= st_cmd;
                    end
                end
                st_cmd:   state <= st_latch;
                st_latch: state <= st_resp;
                st_resp: begin
                    if (write_q ? bready : rready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= araddr;
        end else if (aw_hs) begin
            addr_q <= awaddr;
        end
        if (w_hs) begin
            wdata_q <= wdata;
        end
        // Queue answer is valid one cycle after start
        if (state == st_latch) begin
            rdata_q <= cmd.rdata;
            resp_q  <= cmd.err ? slverr : okay;
        end
    end

    assign cmd.start = (state == st_cmd);
    assign cmd.write = write_q;
    assign cmd.addr  = addr_q;
    assign cmd.wdata = wdata_q;

    assign bvalid = (state == st_resp) && write_q;
    assign rvalid = (state == st_resp) && !write_q;
    assign bresp  = resp_q;
    assign rresp  = resp_q;
    assign rdata  = rdata_q;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

/* mmio_cmd_if.sv */
`default_nettype none

// One-cycle command bus, response valid the cycle after start
interface mmio_cmd_if;
    import uart_tx_pkg::*;

    logic  start;
    logic  write;
    addr_t addr;
    data_t wdata;
    data_t rdata;
    logic  err;

    modport master (
        output start, write, addr, wdata,
        input  rdata, err
    );

    modport slave (
        input  start, write, addr, wdata,
        output rdata, err
    );

endinterface

`default_nettype wire

/* uart_tx_pkg.sv */
`default_nettype none

package uart_tx_pkg;

    // Peripheral byte address and bus word
    typedef logic [11:0] addr_t;
    typedef logic [31:0] data_t;

    // Ring index, upper 6 bits pick the word, lower 2 bits the byte
    typedef logic [7:0] ptr_t;

    localparam int buf_words = 64;

    localparam addr_t head_offset = 12'h100;
    localparam addr_t tail_offset = 12'h104;

    typedef enum logic [1:0] {
        okay   = 2'd0,
        slverr = 2'd2
    } axi_resp_t;

    // Drain engine of the queue
    typedef enum logic [1:0] {
        q_idle,
        q_fetch,
        q_wait_ready
    } queue_state_t;

    // Frame sequencer of the serializer
    typedef enum logic [1:0] {
        ser_idle,
        ser_start_bit,
        ser_data_bits,
        ser_stop_bit
    } ser_state_t;

endpackage

`default_nettype wire
